//--- zf_pkg.sv
`default_nettype none

package zf_pkg;

    // ------------------------------
    // data path widths
    // ------------------------------
    localparam int DATA_W     = 64;
    localparam int MEM_ADDR_W = 16;
    localparam int LEN_W      = 16;

    // register port, page in the top two address bits
    localparam int REG_ADDR_W = 10;
    localparam int REG_IDX_W  = 8;
    localparam int REG_DATA_W = 32;
    localparam int PAGE_W     = REG_ADDR_W - REG_IDX_W;

    localparam logic [PAGE_W-1:0] PAGE_S2H  = 2'd0;
    localparam logic [PAGE_W-1:0] PAGE_DEST = 2'd2;

    // ------------------------------
    // streams and command queues
    // ------------------------------
    localparam int STREAMS       = 4;
    localparam int STREAM_W      = 2;
    localparam int CMDFIFO_DEPTH = 4;
    localparam int PTR_W         = 2;
    localparam int CNT_W         = 3;
    localparam int DONE_CNT_W    = 8;

    // destination table, indexed from first word bits [19:16]
    localparam int DEST_IDX_W   = 4;
    localparam int DEST_IDX_LSB = 16;
    localparam int DEST_ENTRIES = 2 ** DEST_IDX_W;

    // register indices inside the arbiter page
    localparam logic [REG_IDX_W-1:0] REG_CMD0  = 8'd0;
    localparam logic [REG_IDX_W-1:0] REG_OCC0  = 8'd0;
    localparam logic [REG_IDX_W-1:0] REG_DONE0 = 8'd4;
    localparam logic [REG_IDX_W-1:0] REG_IRQ   = 8'd8;

    // writer FSM
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        ACTIVE = 2'd1,
        STATUS = 2'd2
    } wr_state_e;

endpackage

`default_nettype wire

//--- zf_dest_lookup.sv
`default_nettype none

module zf_dest_lookup (
    input  wire                           clk,
    input  wire                           rst,

    // table programming
    input  wire                           i_set_stb,
    input  wire [zf_pkg::DEST_IDX_W-1:0]  i_set_idx,
    input  wire [zf_pkg::STREAM_W-1:0]    i_set_data,

    // stream in
    input  wire [zf_pkg::DATA_W-1:0]      i_tdata,
    input  wire                           i_tlast,
    input  wire                           i_tvalid,
    output logic                          o_tready,

    // stream out with its tag
    output logic [zf_pkg::DATA_W-1:0]     o_tdata,
    output logic                          o_tlast,
    output logic                          o_tvalid,
    input  wire                           i_tready,
    output logic [zf_pkg::STREAM_W-1:0]   o_tdest
);

    import zf_pkg::*;

    logic [STREAM_W-1:0]   dest_table [DEST_ENTRIES];
    logic                  first_beat;
    logic [STREAM_W-1:0]   dest_held;
    logic [DEST_IDX_W-1:0] lookup_idx;
    logic [STREAM_W-1:0]   lookup_dest;
    logic                  beat_xfer;

    // the stream itself passes straight through
    assign o_tdata   = i_tdata;
    assign o_tlast   = i_tlast;
    assign o_tvalid  = i_tvalid;
    assign o_tready  = i_tready;
    assign beat_xfer = i_tvalid && i_tready;

    assign lookup_idx  = i_tdata[DEST_IDX_LSB +: DEST_IDX_W];
    assign lookup_dest = dest_table[lookup_idx];

    // first beat reads the table, later beats use the held tag
    assign o_tdest = first_beat ? lookup_dest : dest_held;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEST_ENTRIES; i++) begin
                dest_table[i] <= '0;
            end
        end else if (i_set_stb) begin
            dest_table[i_set_idx] <= i_set_data;
        end
    end

    // next beat starts a packet once tlast has gone through
    always_ff @(posedge clk) begin
        if (rst) begin
            first_beat <= 1'b1;
        end else if (beat_xfer) begin
            first_beat <= i_tlast;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_xfer && first_beat) begin
            dest_held <= lookup_dest;
        end
    end

endmodule

`default_nettype wire

//--- zf_cmd_arbiter.sv
`default_nettype none

module zf_cmd_arbiter (
    input  wire                            clk,
    input  wire                            rst,

    // register port, page already decoded
    input  wire                            i_set_stb,
    input  wire [zf_pkg::REG_IDX_W-1:0]    i_set_idx,
    input  wire [zf_pkg::REG_DATA_W-1:0]   i_set_data,
    input  wire                            i_rb_stb,
    input  wire [zf_pkg::REG_IDX_W-1:0]    i_rb_idx,
    output logic [zf_pkg::REG_DATA_W-1:0]  o_rb_data,

    // stream waiting at the writer
    input  wire                            i_stream_valid,
    input  wire [zf_pkg::STREAM_W-1:0]     i_stream_dest,

    // command to writer
    output logic                           o_cmd_valid,
    input  wire                            i_cmd_ready,
    output logic [zf_pkg::STREAM_W-1:0]    o_cmd_stream,
    output logic [zf_pkg::MEM_ADDR_W-1:0]  o_cmd_addr,
    output logic [zf_pkg::LEN_W-1:0]       o_cmd_len,

    // status from writer
    input  wire                            i_sts_valid,
    input  wire [zf_pkg::STREAM_W-1:0]     i_sts_stream,
    input  wire [zf_pkg::LEN_W-1:0]        i_sts_words,
    input  wire                            i_sts_trunc,

    output logic                           o_irq
);

    import zf_pkg::*;

    logic [MEM_ADDR_W-1:0] fifo_addr [STREAMS][CMDFIFO_DEPTH];
    logic [LEN_W-1:0]      fifo_len  [STREAMS][CMDFIFO_DEPTH];
    logic [PTR_W-1:0]      rd_ptr    [STREAMS];
    logic [PTR_W-1:0]      wr_ptr    [STREAMS];
    logic [CNT_W-1:0]      count     [STREAMS];
    logic [DONE_CNT_W-1:0] done_cnt  [STREAMS];
    logic [LEN_W-1:0]      last_words [STREAMS];
    logic [STREAMS-1:0]    last_trunc;
    logic [STREAMS-1:0]    pending;
    logic [STREAMS-1:0]    push;
    logic [STREAMS-1:0]    pop;
    logic [STREAMS-1:0]    sts_set;
    logic [STREAMS-1:0]    irq_clr;
    logic                  wr_busy;
    logic                  issue;
    logic                  cmd_xfer;
    logic [REG_DATA_W-1:0] rb_next;

    // ------------------------------
    // register decode
    // ------------------------------
    always_comb begin
        for (int s = 0; s < STREAMS; s++) begin
            // a push to a full queue is dropped
            push[s]    = i_set_stb && (i_set_idx == REG_CMD0 + REG_IDX_W'(s)) &&
                         (count[s] != CNT_W'(CMDFIFO_DEPTH));
            pop[s]     = cmd_xfer && (o_cmd_stream == STREAM_W'(s));
            sts_set[s] = i_sts_valid && (i_sts_stream == STREAM_W'(s));
        end
        irq_clr = (i_set_stb && (i_set_idx == REG_IRQ)) ? i_set_data[STREAMS-1:0] : '0;
    end

    // ------------------------------
    // per-stream command queues
    // ------------------------------
    always_ff @(posedge clk) begin
        for (int s = 0; s < STREAMS; s++) begin
            if (push[s]) begin
                fifo_addr[s][wr_ptr[s]] <= i_set_data[MEM_ADDR_W-1:0];
                fifo_len[s][wr_ptr[s]]  <= i_set_data[MEM_ADDR_W +: LEN_W];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < STREAMS; s++) begin
                rd_ptr[s] <= '0;
                wr_ptr[s] <= '0;
                count[s]  <= '0;
            end
        end else begin
            for (int s = 0; s < STREAMS; s++) begin
                if (push[s]) begin
                    wr_ptr[s] <= wr_ptr[s] + 1'b1;
                end
                if (pop[s]) begin
                    rd_ptr[s] <= rd_ptr[s] + 1'b1;
                end
                count[s] <= count[s] + CNT_W'(push[s]) - CNT_W'(pop[s]);
            end
        end
    end

    // ------------------------------
    // command issue
    // ------------------------------
    // one command in flight, only for the stream whose data is waiting
    assign issue    = !o_cmd_valid && !wr_busy && i_stream_valid &&
                      (count[i_stream_dest] != '0);
    assign cmd_xfer = o_cmd_valid && i_cmd_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            o_cmd_valid  <= 1'b0;
            o_cmd_stream <= '0;
            wr_busy      <= 1'b0;
        end else begin
            if (issue) begin
                o_cmd_valid  <= 1'b1;
                o_cmd_stream <= i_stream_dest;
            end else if (cmd_xfer) begin
                o_cmd_valid <= 1'b0;
            end
            // busy until the writer reports back
            if (cmd_xfer) begin
                wr_busy <= 1'b1;
            end else if (i_sts_valid) begin
                wr_busy <= 1'b0;
            end
        end
    end

    // head stays put until the pop
    assign o_cmd_addr = fifo_addr[o_cmd_stream][rd_ptr[o_cmd_stream]];
    assign o_cmd_len  = fifo_len[o_cmd_stream][rd_ptr[o_cmd_stream]];

    // ------------------------------
    // completion and interrupt
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < STREAMS; s++) begin
                done_cnt[s]   <= '0;
                last_words[s] <= '0;
            end
            last_trunc <= '0;
            pending    <= '0;
        end else begin
            for (int s = 0; s < STREAMS; s++) begin
                if (sts_set[s]) begin
                    done_cnt[s]   <= done_cnt[s] + 1'b1;
                    last_words[s] <= i_sts_words;
                    last_trunc[s] <= i_sts_trunc;
                end
            end
            // a new completion wins over a clear in the same cycle
            pending <= (pending & ~irq_clr) | sts_set;
        end
    end

    assign o_irq = |pending;

    // readback
    always_comb begin
        rb_next = '0;
        for (int s = 0; s < STREAMS; s++) begin
            if (i_rb_idx == REG_OCC0 + REG_IDX_W'(s)) begin
                rb_next = REG_DATA_W'(count[s]);
            end
            if (i_rb_idx == REG_DONE0 + REG_IDX_W'(s)) begin
                rb_next = {7'd0, last_trunc[s], last_words[s], done_cnt[s]};
            end
        end
        if (i_rb_idx == REG_IRQ) begin
            rb_next = REG_DATA_W'(pending);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_rb_data <= '0;
        end else if (i_rb_stb) begin
            o_rb_data <= rb_next;
        end
    end

endmodule

`default_nettype wire

//--- zf_s2h_writer.sv
`default_nettype none

module zf_s2h_writer (
    input  wire                            clk,
    input  wire                            rst,

    // command in
    input  wire                            i_cmd_valid,
    output logic                           o_cmd_ready,
    input  wire [zf_pkg::STREAM_W-1:0]     i_cmd_stream,
    input  wire [zf_pkg::MEM_ADDR_W-1:0]   i_cmd_addr,
    input  wire [zf_pkg::LEN_W-1:0]        i_cmd_len,

    // stream in
    input  wire [zf_pkg::DATA_W-1:0]       i_tdata,
    input  wire                            i_tlast,
    input  wire                            i_tvalid,
    output logic                           o_tready,

    // buffer memory write port
    output logic                           o_mem_we,
    output logic [zf_pkg::MEM_ADDR_W-1:0]  o_mem_addr,
    output logic [zf_pkg::DATA_W-1:0]      o_mem_data,

    // status out
    output logic                           o_sts_valid,
    output logic [zf_pkg::STREAM_W-1:0]    o_sts_stream,
    output logic [zf_pkg::LEN_W-1:0]       o_sts_words,
    output logic                           o_sts_trunc
);

    import zf_pkg::*;

    wr_state_e             state;
    logic [STREAM_W-1:0]   stream_q;
    logic [MEM_ADDR_W-1:0] base_q;
    logic [LEN_W-1:0]      len_q;
    logic [LEN_W-1:0]      beat_idx;
    logic                  trunc_q;
    logic                  cmd_xfer;
    logic                  beat_xfer;
    logic                  in_range;

    // ready only between a command and its tlast
    assign o_cmd_ready = (state == IDLE);
    assign o_tready    = (state == ACTIVE);
    assign cmd_xfer    = i_cmd_valid && o_cmd_ready;
    assign beat_xfer   = i_tvalid && o_tready;
    assign in_range    = (beat_idx < len_q);

    // ------------------------------
    // FSM
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (cmd_xfer) state <= ACTIVE;
                ACTIVE:  if (beat_xfer && i_tlast) state <= STATUS;
                STATUS:  state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_xfer) begin
            stream_q <= i_cmd_stream;
            base_q   <= i_cmd_addr;
            len_q    <= i_cmd_len;
        end
    end

    // beat index stops at the length, so it is also the word count
    always_ff @(posedge clk) begin
        if (rst) begin
            beat_idx <= '0;
            trunc_q  <= 1'b0;
        end else if (cmd_xfer) begin
            beat_idx <= '0;
            trunc_q  <= 1'b0;
        end else if (beat_xfer) begin
            if (in_range) begin
                beat_idx <= beat_idx + 1'b1;
            end else begin
                trunc_q <= 1'b1;
            end
        end
    end

    // ------------------------------
    // memory write, one cycle after the beat
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            o_mem_we <= 1'b0;
        end else begin
            o_mem_we <= beat_xfer && in_range;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_xfer) begin
            o_mem_addr <= base_q + MEM_ADDR_W'(beat_idx);
            o_mem_data <= i_tdata;
        end
    end

    // status pulse for the single STATUS cycle
    assign o_sts_valid  = (state == STATUS);
    assign o_sts_stream = stream_q;
    assign o_sts_words  = beat_idx;
    assign o_sts_trunc  = trunc_q;

endmodule

`default_nettype wire

//--- zf_fifo_top.sv
`default_nettype none

module zf_fifo_top (
    input  wire                            clk,
    input  wire                            rst,

    // register port
    input  wire                            i_set_stb,
    input  wire [zf_pkg::REG_ADDR_W-1:0]   i_set_addr,
    input  wire [zf_pkg::REG_DATA_W-1:0]   i_set_data,
    input  wire                            i_rb_stb,
    input  wire [zf_pkg::REG_ADDR_W-1:0]   i_rb_addr,
    output logic [zf_pkg::REG_DATA_W-1:0]  o_rb_data,

    // stream to host
    input  wire [zf_pkg::DATA_W-1:0]       i_s2h_tdata,
    input  wire                            i_s2h_tlast,
    input  wire                            i_s2h_tvalid,
    output logic                           o_s2h_tready,

    // buffer memory
    output logic                           o_mem_we,
    output logic [zf_pkg::MEM_ADDR_W-1:0]  o_mem_addr,
    output logic [zf_pkg::DATA_W-1:0]      o_mem_data,

    output logic                           o_irq
);

    import zf_pkg::*;

    logic [PAGE_W-1:0]     set_page;
    logic [PAGE_W-1:0]     rb_page;
    logic [PAGE_W-1:0]     rb_page_q;
    logic [REG_DATA_W-1:0] rb_data_s2h;

    logic [DATA_W-1:0]     lk_tdata;
    logic                  lk_tlast;
    logic                  lk_tvalid;
    logic                  lk_tready;
    logic [STREAM_W-1:0]   lk_tdest;

    logic                  cmd_valid;
    logic                  cmd_ready;
    logic [STREAM_W-1:0]   cmd_stream;
    logic [MEM_ADDR_W-1:0] cmd_addr;
    logic [LEN_W-1:0]      cmd_len;

    logic                  sts_valid;
    logic [STREAM_W-1:0]   sts_stream;
    logic [LEN_W-1:0]      sts_words;
    logic                  sts_trunc;

    // ------------------------------
    // page decode and readback
    // ------------------------------
    assign set_page = i_set_addr[REG_ADDR_W-1:REG_IDX_W];
    assign rb_page  = i_rb_addr[REG_ADDR_W-1:REG_IDX_W];

    // page of the last read picks the source, unmapped pages read zero
    always_ff @(posedge clk) begin
        if (rst) begin
            rb_page_q <= PAGE_S2H;
        end else if (i_rb_stb) begin
            rb_page_q <= rb_page;
        end
    end

    assign o_rb_data = (rb_page_q == PAGE_S2H) ? rb_data_s2h : '0;

    zf_dest_lookup u_dest_lookup (
        .clk        (clk),
        .rst        (rst),
        .i_set_stb  (i_set_stb && (set_page == PAGE_DEST)),
        .i_set_idx  (i_set_addr[DEST_IDX_W-1:0]),
        .i_set_data (i_set_data[STREAM_W-1:0]),
        .i_tdata    (i_s2h_tdata),
        .i_tlast    (i_s2h_tlast),
        .i_tvalid   (i_s2h_tvalid),
        .o_tready   (o_s2h_tready),
        .o_tdata    (lk_tdata),
        .o_tlast    (lk_tlast),
        .o_tvalid   (lk_tvalid),
        .i_tready   (lk_tready),
        .o_tdest    (lk_tdest)
    );

    zf_cmd_arbiter u_cmd_arbiter (
        .clk            (clk),
        .rst            (rst),
        .i_set_stb      (i_set_stb && (set_page == PAGE_S2H)),
        .i_set_idx      (i_set_addr[REG_IDX_W-1:0]),
        .i_set_data     (i_set_data),
        .i_rb_stb       (i_rb_stb && (rb_page == PAGE_S2H)),
        .i_rb_idx       (i_rb_addr[REG_IDX_W-1:0]),
        .o_rb_data      (rb_data_s2h),
        .i_stream_valid (lk_tvalid),
        .i_stream_dest  (lk_tdest),
        .o_cmd_valid    (cmd_valid),
        .i_cmd_ready    (cmd_ready),
        .o_cmd_stream   (cmd_stream),
        .o_cmd_addr     (cmd_addr),
        .o_cmd_len      (cmd_len),
        .i_sts_valid    (sts_valid),
        .i_sts_stream   (sts_stream),
        .i_sts_words    (sts_words),
        .i_sts_trunc    (sts_trunc),
        .o_irq          (o_irq)
    );

    zf_s2h_writer u_s2h_writer (
        .clk          (clk),
        .rst          (rst),
        .i_cmd_valid  (cmd_valid),
        .o_cmd_ready  (cmd_ready),
        .i_cmd_stream (cmd_stream),
        .i_cmd_addr   (cmd_addr),
        .i_cmd_len    (cmd_len),
        .i_tdata      (lk_tdata),
        .i_tlast      (lk_tlast),
        .i_tvalid     (lk_tvalid),
        .o_tready     (lk_tready),
        .o_mem_we     (o_mem_we),
        .o_mem_addr   (o_mem_addr),
        .o_mem_data   (o_mem_data),
        .o_sts_valid  (sts_valid),
        .o_sts_stream (sts_stream),
        .o_sts_words  (sts_words),
        .o_sts_trunc  (sts_trunc)
    );

endmodule

`default_nettype wire

//--- zf_fifo_sva.sv
`default_nettype none

module zf_fifo_sva (
    input wire       clk,
    input wire       rst,
    input wire       i_tready,
    input wire [1:0] i_wr_state,
    input wire       i_cmd_valid,
    input wire       i_cmd_ready,
    input wire       i_sts_valid,
    input wire       i_irq
);

    import zf_pkg::*;

    // failed assertions so far
    int fail_cnt = 0;

    // ------------------------------
    // stream and command handshakes
    // ------------------------------
    tready_only_active: assert property (
        @(posedge clk) disable iff (rst) i_tready |-> (i_wr_state == ACTIVE)
    ) else begin
        fail_cnt++;
        $error("stream ready high while the writer is not in ACTIVE");
    end

    cmd_valid_hold: assert property (
        @(posedge clk) disable iff (rst) (i_cmd_valid && !i_cmd_ready) |=> i_cmd_valid
    ) else begin
        fail_cnt++;
        $error("command valid dropped before the writer took it");
    end

    // status is a single pulse
    sts_one_cycle: assert property (
        @(posedge clk) disable iff (rst) i_sts_valid |=> !i_sts_valid
    ) else begin
        fail_cnt++;
        $error("status valid lasted more than one cycle");
    end

    irq_low_after_reset: assert property (
        @(posedge clk) rst |=> !i_irq
    ) else begin
        fail_cnt++;
        $error("interrupt high right after reset");
    end

endmodule

`default_nettype wire

//--- tb_zf_fifo_top.sv
`default_nettype none

module tb_zf_fifo_top;

    import zf_pkg::*;

    logic                  clk;
    logic                  rst;
    logic                  set_stb;
    logic [REG_ADDR_W-1:0] set_addr;
    logic [REG_DATA_W-1:0] set_data;
    logic                  rb_stb;
    logic [REG_ADDR_W-1:0] rb_addr;
    wire  [REG_DATA_W-1:0] rb_data;
    logic [DATA_W-1:0]     s2h_tdata;
    logic                  s2h_tlast;
    logic                  s2h_tvalid;
    wire                   s2h_tready;
    wire                   mem_we;
    wire  [MEM_ADDR_W-1:0] mem_addr;
    wire  [DATA_W-1:0]     mem_data;
    wire                   irq;

    // memory model and expected writes as {addr, data}
    logic [DATA_W-1:0]     mem [2**MEM_ADDR_W];
    logic [79:0]           exp_q [$];
    logic [79:0]           exp_head;
    logic [31:0]           lcg_state;
    logic [DATA_W-1:0]     pkt [8];

    // model of the table and of the command queues
    logic [STREAM_W-1:0]   table_model [DEST_ENTRIES];
    logic [31:0]           cmd_model [STREAMS][CMDFIFO_DEPTH];
    int                    cmd_rd [STREAMS];
    int                    cmd_cnt [STREAMS];
    int                    done_model [STREAMS];

    initial clk = 1'b0;
    always #2 clk = ~clk;

    zf_fifo_top dut (
        .clk          (clk),
        .rst          (rst),
        .i_set_stb    (set_stb),
        .i_set_addr   (set_addr),
        .i_set_data   (set_data),
        .i_rb_stb     (rb_stb),
        .i_rb_addr    (rb_addr),
        .o_rb_data    (rb_data),
        .i_s2h_tdata  (s2h_tdata),
        .i_s2h_tlast  (s2h_tlast),
        .i_s2h_tvalid (s2h_tvalid),
        .o_s2h_tready (s2h_tready),
        .o_mem_we     (mem_we),
        .o_mem_addr   (mem_addr),
        .o_mem_data   (mem_data),
        .o_irq        (irq)
    );

    bind zf_fifo_top zf_fifo_sva u_sva (
        .clk         (clk),
        .rst         (rst),
        .i_tready    (o_s2h_tready),
        .i_wr_state  (u_s2h_writer.state),
        .i_cmd_valid (cmd_valid),
        .i_cmd_ready (cmd_ready),
        .i_sts_valid (sts_valid),
        .i_irq       (o_irq)
    );

    // ------------------------------
    // helpers
    // ------------------------------
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [DATA_W-1:0] fill_word(input logic [MEM_ADDR_W-1:0] a);
        return {a, ~a, a ^ 16'h5a5a, a + 16'h1234};
    endfunction

    // words written and truncated flag for a command length and a packet length
    function automatic logic [LEN_W:0] ref_status(input logic [LEN_W-1:0] len, input int beats);
        logic [LEN_W-1:0] words;
        words = (beats < len) ? LEN_W'(beats) : len;
        return {(beats > len), words};
    endfunction

    task automatic stop_fail();
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_fail();
        end
    endtask

    task automatic reg_write(input logic [REG_ADDR_W-1:0] addr, input logic [31:0] data);
        @(posedge clk);
        set_stb  <= 1'b1;
        set_addr <= addr;
        set_data <= data;
        @(posedge clk);
        set_stb <= 1'b0;
    endtask

    // data shows up the cycle after the strobe
    task automatic reg_read_check(input string name, input logic [REG_ADDR_W-1:0] addr,
                                  input logic [31:0] exp);
        @(posedge clk);
        rb_stb  <= 1'b1;
        rb_addr <= addr;
        @(posedge clk);
        rb_stb <= 1'b0;
        @(negedge clk);
        check_val(name, rb_data, exp);
    endtask

    task automatic queue_cmd(input int s, input logic [15:0] base, input logic [15:0] len);
        if (cmd_cnt[s] < CMDFIFO_DEPTH) begin
            cmd_model[s][(cmd_rd[s] + cmd_cnt[s]) % CMDFIFO_DEPTH] = {len, base};
            cmd_cnt[s]++;
        end
        reg_write({PAGE_S2H, REG_CMD0 + 8'(s)}, {len, base});
    endtask

    task automatic make_packet(input int idx, input int n);
        for (int i = 0; i < n; i++) begin
            pkt[i] = {lcg_next(), lcg_next()};
        end
        pkt[0][DEST_IDX_LSB +: DEST_IDX_W] = DEST_IDX_W'(idx);
    endtask

    task automatic send_beats(input int n);
        int stall;
        int wait_cnt;
        for (int i = 0; i < n; i++) begin
            stall = (i == 0) ? 0 : int'((lcg_next() >> 20) % 3);
            @(posedge clk);
            if (stall > 0) begin
                s2h_tvalid <= 1'b0;
                repeat (stall) @(posedge clk);
            end
            s2h_tvalid <= 1'b1;
            s2h_tdata  <= pkt[i];
            s2h_tlast  <= (i == n - 1);
            wait_cnt = 0;
            do begin
                @(negedge clk);
                wait_cnt++;
                assert (wait_cnt < 200) else begin
                    $display("timeout: beat %0d of the packet was never accepted", i);
                    stop_fail();
                end
            end while (!s2h_tready);
        end
        @(posedge clk);
        s2h_tvalid <= 1'b0;
        s2h_tlast  <= 1'b0;
    endtask

    // hold keeps the first beat waiting with no command, then queues base and len
    task automatic run_packet(input int idx, input int n, input logic hold,
                              input logic [15:0] base, input logic [15:0] len);
        int                    s;
        int                    wait_cnt;
        logic [31:0]           cmd;
        logic [LEN_W:0]        sts;
        logic [MEM_ADDR_W-1:0] after_addr;
        s = table_model[idx];
        make_packet(idx, n);
        if (hold) begin
            @(posedge clk);
            s2h_tvalid <= 1'b1;
            s2h_tdata  <= pkt[0];
            s2h_tlast  <= (n == 1);
            repeat (50) begin
                @(negedge clk);
                check_val("o_s2h_tready", s2h_tready, 0);
                check_val("o_mem_we", mem_we, 0);
            end
            queue_cmd(s, base, len);
        end
        assert (cmd_cnt[s] > 0) else begin
            $display("no command is queued for stream %0d", s);
            stop_fail();
        end
        cmd = cmd_model[s][cmd_rd[s]];
        cmd_rd[s] = (cmd_rd[s] + 1) % CMDFIFO_DEPTH;
        cmd_cnt[s]--;
        sts = ref_status(cmd[31:16], n);
        for (int i = 0; i < sts[LEN_W-1:0]; i++) begin
            exp_q.push_back({cmd[15:0] + 16'(i), pkt[i]});
        end
        done_model[s]++;
        send_beats(n);
        wait_cnt = 0;
        do begin
            @(negedge clk);
            wait_cnt++;
            assert (wait_cnt < 100) else begin
                $display("timeout: no interrupt after a packet for stream %0d", s);
                stop_fail();
            end
        end while (!irq);
        reg_read_check("irq pending", {PAGE_S2H, REG_IRQ}, 32'(1) << s);
        reg_read_check("done register", {PAGE_S2H, REG_DONE0 + 8'(s)},
                       {7'd0, sts, 8'(done_model[s])});
        check_val("pending memory writes", exp_q.size(), 0);
        // word past the written range keeps its fill
        after_addr = cmd[15:0] + sts[LEN_W-1:0];
        check_val("mem after last word", mem[after_addr], fill_word(after_addr));
        reg_write({PAGE_S2H, REG_IRQ}, 32'(1) << s);
        @(negedge clk);
        check_val("o_irq", irq, 0);
    endtask

    // ------------------------------
    // memory write compare
    // ------------------------------
    always @(negedge clk) begin
        if (!rst && mem_we) begin
            assert (exp_q.size() > 0) else begin
                $display("unexpected memory write to address %h", mem_addr);
                stop_fail();
            end
            exp_head = exp_q.pop_front();
            check_val("o_mem_addr", mem_addr, exp_head[79:64]);
            check_val("o_mem_data", mem_data, exp_head[63:0]);
            mem[mem_addr] = mem_data;
        end
    end

    // failures of the bound assertions
    always @(negedge clk) begin
        if (dut.u_sva.fail_cnt != 0) begin
            $display("a bound assertion on the DUT handshakes failed");
            stop_fail();
        end
    end

    // ------------------------------
    // stimulus
    // ------------------------------
    initial begin
        int          idx;
        int          n;
        logic [15:0] len;
        lcg_state  = 32'hcf28;
        rst        = 1'b1;
        set_stb    = 1'b0;
        set_addr   = '0;
        set_data   = '0;
        rb_stb     = 1'b0;
        rb_addr    = '0;
        s2h_tdata  = '0;
        s2h_tlast  = 1'b0;
        s2h_tvalid = 1'b0;
        for (int a = 0; a < 2**MEM_ADDR_W; a++) begin
            mem[a] = fill_word(16'(a));
        end
        for (int s = 0; s < STREAMS; s++) begin
            cmd_rd[s]     = 0;
            cmd_cnt[s]    = 0;
            done_model[s] = 0;
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // random destination table
        for (int i = 0; i < DEST_ENTRIES; i++) begin
            table_model[i] = STREAM_W'(lcg_next() >> 24);
            reg_write({PAGE_DEST, 8'(i)}, 32'(table_model[i]));
        end

        // routing and data, command length equal or one above
        for (int p = 0; p < 12; p++) begin
            idx = int'((lcg_next() >> 16) % 16);
            n   = int'((lcg_next() >> 16) % 8) + 1;
            len = 16'(n + int'((lcg_next() >> 28) % 2));
            queue_cmd(table_model[idx], 16'(p * 32), len);
            run_packet(idx, n, 1'b0, '0, '0);
        end

        // packets longer than their command
        for (int p = 12; p < 14; p++) begin
            idx = int'((lcg_next() >> 16) % 16);
            queue_cmd(table_model[idx], 16'(p * 32), 16'd3);
            run_packet(idx, 6, 1'b0, '0, '0);
        end

        // back-pressure until the command arrives
        idx = int'((lcg_next() >> 16) % 16);
        run_packet(idx, 4, 1'b1, 16'(14 * 32), 16'd4);

        // fill stream 3 queue, the fifth push is dropped
        table_model[15] = 2'd3;
        reg_write({PAGE_DEST, 8'd15}, 32'd3);
        for (int k = 0; k < 5; k++) begin
            queue_cmd(3, 16'((15 + k) * 32), 16'd8);
            reg_read_check("occupancy", {PAGE_S2H, REG_OCC0 + 8'd3}, 32'((k < 4) ? k + 1 : 4));
        end
        // arbiter readback now holds a nonzero count, page 2 still reads zero
        reg_read_check("unmapped page", {PAGE_DEST, REG_OCC0 + 8'd3}, 32'd0);
        for (int k = 0; k < 4; k++) begin
            n = int'((lcg_next() >> 16) % 8) + 1;
            run_packet(15, n, 1'b0, '0, '0);
            reg_read_check("occupancy", {PAGE_S2H, REG_OCC0 + 8'd3}, 32'(3 - k));
        end

        if (dut.u_sva.fail_cnt == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("a bound assertion on the DUT handshakes failed");
            stop_fail();
        end
    end

endmodule

`default_nettype wire

//--- zf_fifo.f
zf_pkg.sv
zf_dest_lookup.sv
zf_cmd_arbiter.sv
zf_s2h_writer.sv
zf_fifo_top.sv
zf_fifo_sva.sv
tb_zf_fifo_top.sv

//--- Bender.yml
package:
  name: zf_fifo

sources:
  - files:
      - zf_pkg.sv
      - zf_dest_lookup.sv
      - zf_cmd_arbiter.sv
      - zf_s2h_writer.sv
      - zf_fifo_top.sv
  - target: test
    files:
      - zf_fifo_sva.sv
      - tb_zf_fifo_top.sv
